/* Bender.yml */
package:
  name: cpu16
  authors: []

sources:
  - include_dirs:
      - hw
    files:
      - hw/cpu_pkg.sv
      - hw/cpu_ctrl_if.sv
      - hw/regfile.sv
      - hw/alu.sv
      - hw/cpu_control.sv
      - hw/cpu_datapath.sv
      - hw/cpu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/cpu_tb_assert.sv
      - tests/cpu_tb.sv

/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu #(
  parameter int WIDTH = 16
) (
  input  var  cpu_pkg::alu_op_e   i_op,
  input  wire logic [WIDTH-1:0]   i_a,
  input  wire logic [WIDTH-1:0]   i_b,
  output logic      [WIDTH-1:0]   o_result,
  output logic                    o_n,
  output logic                    o_z
);

  // cmp and cmpi reuse the subtract path
  always_comb begin
    case (i_op)
      cpu_pkg::ALU_SUB: o_result = i_a - i_b;
      default:          o_result = i_a + i_b;
    endcase
  end

  // Sign bit and all-zero result
  assign o_n = o_result[WIDTH-1];
  assign o_z = (o_result == '0);

endmodule

`default_nettype wire

/* hw/cpu_control.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_control (
  input  wire logic i_clk,
  input  wire logic i_reset,
  cpu_ctrl_if.ctrl  ctrl,
  output logic      o_ldst_write
);

  localparam int              RA_W = $clog2(`CPU_NUM_REGS);
  localparam logic [RA_W-1:0] LINK = `CPU_LINK_REG;

  // Arithmetic forms, these update N and Z
  function automatic logic sets_flags(cpu_pkg::opcode_e op);
    return op inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_CMP,
                      cpu_pkg::OP_ADDI, cpu_pkg::OP_SUBI, cpu_pkg::OP_CMPI};
  endfunction

  // Anything with a register result
  function automatic logic writes_rf(cpu_pkg::opcode_e op);
    return op inside {cpu_pkg::OP_MV, cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_MVI,
                      cpu_pkg::OP_ADDI, cpu_pkg::OP_SUBI, cpu_pkg::OP_MVHI,
                      cpu_pkg::OP_LD, cpu_pkg::OP_CALLR};
  endfunction

  cpu_pkg::opcode_e    op_d, op_e, op_w;
  cpu_pkg::alu_b_sel_e fwd_src;
  logic                r_first, d_kill, jump_reg_e, take_d;
  logic                flag_n_sel, flag_z_sel, wr_w;
  logic [RA_W-1:0]     rx_e, ry_e, dst_w;

  assign op_d = cpu_pkg::opcode_e'(ctrl.ir_d[4:0]);
  assign op_e = cpu_pkg::opcode_e'(ctrl.ir_e[4:0]);
  assign op_w = cpu_pkg::opcode_e'(ctrl.ir_w[4:0]);

  // Fetch data in the first cycle is stale
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      r_first <= 1'b1;
    end else begin
      r_first <= 1'b0;
    end
  end

  // jr/callr redirect from E, one bubble over the word in D
  assign jump_reg_e       = (op_e == cpu_pkg::OP_JR) || (op_e == cpu_pkg::OP_CALLR);
  assign d_kill           = r_first || jump_reg_e;
  assign ctrl.ir_e_bubble = d_kill;

  // Flags of an arithmetic op in E are not yet registered
  assign flag_n_sel = sets_flags(op_e) ? ctrl.flag_n_now : ctrl.flag_n;
  assign flag_z_sel = sets_flags(op_e) ? ctrl.flag_z_now : ctrl.flag_z;

  // Branch decision in D
  always_comb begin
    take_d = 1'b0;
    if (!d_kill) begin
      case (op_d)
        cpu_pkg::OP_J:  take_d = 1'b1;
        cpu_pkg::OP_JZ: take_d = flag_z_sel;
        cpu_pkg::OP_JN: take_d = flag_n_sel;
        default:        take_d = 1'b0;
      endcase
    end
  end

  // Fetch redirect, register jump wins over D
  always_comb begin
    if (jump_reg_e) begin
      ctrl.pc_sel      = cpu_pkg::PC_REG;
      ctrl.pc_addr_sel = cpu_pkg::ADDR_REG;
    end else if (take_d) begin
      ctrl.pc_sel      = cpu_pkg::PC_JMP;
      ctrl.pc_addr_sel = cpu_pkg::ADDR_JMP;
    end else begin
      ctrl.pc_sel      = cpu_pkg::PC_SEQ;
      ctrl.pc_addr_sel = cpu_pkg::ADDR_PC;
    end
  end

  // Memory never stalls, the main pipe always advances
  assign ctrl.pc_ld   = 1'b1;
  assign ctrl.pc_d_ld = 1'b1;
  assign ctrl.ir_e_ld = 1'b1;
  assign ctrl.ir_w_ld = 1'b1;
  // Return address only travels for callr
  assign ctrl.pc_e_ld = (op_d == cpu_pkg::OP_CALLR) && !d_kill;
  assign ctrl.pc_w_ld = (op_e == cpu_pkg::OP_CALLR);

  // Execute stage
  assign ctrl.alu_op    = (op_e inside {cpu_pkg::OP_SUB, cpu_pkg::OP_SUBI,
                                        cpu_pkg::OP_CMP, cpu_pkg::OP_CMPI}) ?
                          cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
  assign ctrl.alu_r_ld  = sets_flags(op_e) && (op_e != cpu_pkg::OP_CMP) &&
                          (op_e != cpu_pkg::OP_CMPI);
  assign ctrl.alu_n_ld  = sets_flags(op_e);
  assign ctrl.alu_z_ld  = sets_flags(op_e);
  assign ctrl.data_w_ld = (op_e == cpu_pkg::OP_MV) || (op_e == cpu_pkg::OP_MVHI);
  assign o_ldst_write   = (op_e == cpu_pkg::OP_ST);

  // W to E forwarding on destination match
  assign rx_e    = ctrl.ir_e[7:5];
  assign ry_e    = ctrl.ir_e[10:8];
  assign wr_w    = writes_rf(op_w);
  assign dst_w   = (op_w == cpu_pkg::OP_CALLR) ? LINK : ctrl.ir_w[7:5];
  assign fwd_src = (op_w == cpu_pkg::OP_LD) ? cpu_pkg::SRC_MEM_FWD : cpu_pkg::SRC_ALU_FWD;

  assign ctrl.alu_a_sel = (wr_w && (dst_w == rx_e)) ? fwd_src : cpu_pkg::SRC_RF;

  // imm8 forms take B from the instruction
  assign ctrl.alu_b_sel = (op_e inside {cpu_pkg::OP_MVI, cpu_pkg::OP_ADDI, cpu_pkg::OP_SUBI,
                                        cpu_pkg::OP_CMPI, cpu_pkg::OP_MVHI}) ?
                          cpu_pkg::SRC_IMM8 :
                          (wr_w && (dst_w == ry_e)) ? fwd_src : cpu_pkg::SRC_RF;

  // Writeback stage
  assign ctrl.rf_write = wr_w;
  assign ctrl.rf_link  = (op_w == cpu_pkg::OP_CALLR);

  always_comb begin
    case (op_w)
      cpu_pkg::OP_MVI:   ctrl.rf_sel = cpu_pkg::WB_IMM8;
      cpu_pkg::OP_MVHI:  ctrl.rf_sel = cpu_pkg::WB_HIGH;
      cpu_pkg::OP_CALLR: ctrl.rf_sel = cpu_pkg::WB_PC;
      cpu_pkg::OP_LD:    ctrl.rf_sel = cpu_pkg::WB_MEM;
      cpu_pkg::OP_MV:    ctrl.rf_sel = cpu_pkg::WB_RY;
      default:           ctrl.rf_sel = cpu_pkg::WB_ALU;
    endcase
  end

endmodule

`default_nettype wire

/* hw/cpu_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

interface cpu_ctrl_if;

  // Load enables
  logic pc_ld, pc_d_ld, pc_e_ld, pc_w_ld;
  logic ir_e_ld, ir_w_ld;
  logic alu_r_ld, alu_n_ld, alu_z_ld, data_w_ld;
  // Squash of the word entering E
  logic ir_e_bubble;

  // Mux selects
  cpu_pkg::pc_sel_e      pc_sel;
  cpu_pkg::pc_addr_sel_e pc_addr_sel;
  cpu_pkg::alu_a_sel_e   alu_a_sel;
  cpu_pkg::alu_b_sel_e   alu_b_sel;
  cpu_pkg::alu_op_e      alu_op;
  cpu_pkg::rf_sel_e      rf_sel;
  logic                  rf_write, rf_link;

  // Status back from datapath
  logic [`CPU_WIDTH-1:0] ir_d, ir_e, ir_w;
  logic                  flag_n, flag_z, flag_n_now, flag_z_now;

  modport ctrl (
    output pc_ld, pc_d_ld, pc_e_ld, pc_w_ld, ir_e_ld, ir_w_ld,
    output alu_r_ld, alu_n_ld, alu_z_ld, data_w_ld, ir_e_bubble,
    output pc_sel, pc_addr_sel, alu_a_sel, alu_b_sel, alu_op, rf_sel, rf_write, rf_link,
    input  ir_d, ir_e, ir_w, flag_n, flag_z, flag_n_now, flag_z_now
  );

  modport dp (
    input  pc_ld, pc_d_ld, pc_e_ld, pc_w_ld, ir_e_ld, ir_w_ld,
    input  alu_r_ld, alu_n_ld, alu_z_ld, data_w_ld, ir_e_bubble,
    input  pc_sel, pc_addr_sel, alu_a_sel, alu_b_sel, alu_op, rf_sel, rf_write, rf_link,
    output ir_d, ir_e, ir_w, flag_n, flag_z, flag_n_now, flag_z_now
  );

endinterface

`default_nettype wire

/* hw/cpu_datapath.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_datapath (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset,
  cpu_ctrl_if.dp                     ctrl,
  input  wire logic [`CPU_WIDTH-1:0] i_pc_rddata,
  input  wire logic [`CPU_WIDTH-1:0] i_ldst_rddata,
  output logic      [`CPU_WIDTH-1:0] o_pc_addr,
  output logic      [`CPU_WIDTH-1:0] o_ldst_addr,
  output logic      [`CPU_WIDTH-1:0] o_ldst_wrdata
);

  localparam int              DW   = `CPU_WIDTH;
  localparam int              RA_W = $clog2(`CPU_NUM_REGS);
  localparam logic [DW-1:0]   STEP = `CPU_INSTR_SIZE;
  localparam logic [RA_W-1:0] LINK = `CPU_LINK_REG;

  // Stage registers
  logic [DW-1:0]   r_pc, r_pc_d, r_pc_e, r_pc_w;
  logic [DW-1:0]   r_ir_e, r_ir_w;
  logic [DW-1:0]   r_alu_r, r_data_w;
  logic            r_flag_n, r_flag_z;

  logic [DW-1:0]   ir_e_in, imm11_d, imm8_e, imm8_w;
  logic [DW-1:0]   pc_seq, jmp_pc, pc_in, pc_ret_w;
  logic [DW-1:0]   rf_datax, rf_datay, rf_data_in;
  logic [RA_W-1:0] rf_addrw;
  logic [DW-1:0]   op_a, op_b, alu_out, mv_data;
  logic            alu_n, alu_z;

  regfile #(
    .WIDTH   (DW),
    .NUMREGS (`CPU_NUM_REGS)
  ) u_regfile (
    .i_clk,
    .i_reset,
    .i_write   (ctrl.rf_write),
    .i_addrw   (rf_addrw),
    .i_addrx   (i_pc_rddata[7:5]),
    .i_addry   (i_pc_rddata[10:8]),
    .i_data_in (rf_data_in),
    .o_datax   (rf_datax),
    .o_datay   (rf_datay)
  );

  alu #(
    .WIDTH (DW)
  ) u_alu (
    .i_op     (ctrl.alu_op),
    .i_a      (op_a),
    .i_b      (op_b),
    .o_result (alu_out),
    .o_n      (alu_n),
    .o_z      (alu_z)
  );

  // Control state of the pipe
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      r_pc     <= '0;
      r_pc_d   <= '0;
      r_ir_e   <= `CPU_NOP;
      r_ir_w   <= `CPU_NOP;
      r_flag_n <= 1'b0;
      r_flag_z <= 1'b0;
    end else begin
      if (ctrl.pc_ld)    r_pc     <= pc_in;
      // Address actually fetched, whatever its source
      if (ctrl.pc_d_ld)  r_pc_d   <= o_pc_addr;
      if (ctrl.ir_e_ld)  r_ir_e   <= ir_e_in;
      if (ctrl.ir_w_ld)  r_ir_w   <= r_ir_e;
      if (ctrl.alu_n_ld) r_flag_n <= alu_n;
      if (ctrl.alu_z_ld) r_flag_z <= alu_z;
    end
  end

  // Payload registers
  always_ff @(posedge i_clk) begin
    if (ctrl.pc_e_ld)   r_pc_e   <= r_pc_d;
    if (ctrl.pc_w_ld)   r_pc_w   <= r_pc_e;
    if (ctrl.alu_r_ld)  r_alu_r  <= alu_out;
    if (ctrl.data_w_ld) r_data_w <= mv_data;
  end

  // Fetch, r_pc is the sequential fetch address
  assign imm11_d = {{(DW-11){i_pc_rddata[15]}}, i_pc_rddata[15:5]};
  assign pc_seq  = r_pc + STEP;
  // Own address plus 2 plus twice imm11
  assign jmp_pc  = r_pc_d + STEP + {imm11_d[DW-2:0], 1'b0};

  always_comb begin
    case (ctrl.pc_addr_sel)
      cpu_pkg::ADDR_JMP: o_pc_addr = jmp_pc;
      cpu_pkg::ADDR_REG: o_pc_addr = op_a;
      default:           o_pc_addr = r_pc;
    endcase
  end

  always_comb begin
    case (ctrl.pc_sel)
      cpu_pkg::PC_JMP: pc_in = jmp_pc + STEP;
      cpu_pkg::PC_REG: pc_in = op_a + STEP;
      default:         pc_in = pc_seq;
    endcase
  end

  // Decode, killed words become nop
  assign ir_e_in = ctrl.ir_e_bubble ? `CPU_NOP : i_pc_rddata;

  // Execute operands with W forwarding
  assign imm8_e = {{(DW-8){r_ir_e[15]}}, r_ir_e[15:8]};

  always_comb begin
    case (ctrl.alu_a_sel)
      cpu_pkg::SRC_ALU_FWD: op_a = rf_data_in;
      cpu_pkg::SRC_MEM_FWD: op_a = i_ldst_rddata;
      default:              op_a = rf_datax;
    endcase
    case (ctrl.alu_b_sel)
      cpu_pkg::SRC_ALU_FWD: op_b = rf_data_in;
      cpu_pkg::SRC_MEM_FWD: op_b = i_ldst_rddata;
      cpu_pkg::SRC_IMM8:    op_b = imm8_e;
      default:              op_b = rf_datay;
    endcase
  end

  // Rx for mvhi low byte, Ry for mv
  assign mv_data = (ctrl.alu_b_sel == cpu_pkg::SRC_IMM8) ? op_a : op_b;

  // Store address Ry, data Rx
  assign o_ldst_addr   = op_b;
  assign o_ldst_wrdata = op_a;

  // Writeback
  assign imm8_w   = {{(DW-8){r_ir_w[15]}}, r_ir_w[15:8]};
  assign pc_ret_w = r_pc_w + STEP;
  assign rf_addrw = ctrl.rf_link ? LINK : r_ir_w[7:5];

  always_comb begin
    case (ctrl.rf_sel)
      cpu_pkg::WB_IMM8: rf_data_in = imm8_w;
      cpu_pkg::WB_HIGH: rf_data_in = {r_ir_w[15:8], r_data_w[7:0]};
      cpu_pkg::WB_PC:   rf_data_in = pc_ret_w;
      cpu_pkg::WB_MEM:  rf_data_in = i_ldst_rddata;
      cpu_pkg::WB_RY:   rf_data_in = r_data_w;
      default:          rf_data_in = r_alu_r;
    endcase
  end

  // Status to control
  assign ctrl.ir_d       = i_pc_rddata;
  assign ctrl.ir_e       = r_ir_e;
  assign ctrl.ir_w       = r_ir_w;
  assign ctrl.flag_n     = r_flag_n;
  assign ctrl.flag_z     = r_flag_z;
  assign ctrl.flag_n_now = alu_n;
  assign ctrl.flag_z_now = alu_z;

endmodule

`default_nettype wire

/* hw/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data and instruction word width
`define CPU_WIDTH 16

// General purpose registers
`define CPU_NUM_REGS 8

// Byte step between instructions
`define CPU_INSTR_SIZE 2

// Return address target of callr
`define CPU_LINK_REG 7

// All-ones word, also IR reset value
`define CPU_NOP {`CPU_WIDTH{1'b1}}

`endif

/* hw/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  // Opcode field, instruction bits 4:0
  typedef enum logic [4:0] {
    OP_MV    = 5'h00,
    OP_ADD   = 5'h01,
    OP_SUB   = 5'h02,
    OP_CMP   = 5'h03,
    OP_LD    = 5'h04,
    OP_ST    = 5'h05,
    OP_JR    = 5'h08,
    OP_CALLR = 5'h0C,
    OP_MVI   = 5'h10,
    OP_ADDI  = 5'h11,
    OP_SUBI  = 5'h12,
    OP_CMPI  = 5'h13,
    OP_MVHI  = 5'h16,
    OP_J     = 5'h18,
    OP_JZ    = 5'h19,
    OP_JN    = 5'h1A,
    OP_NOP   = 5'h1F
  } opcode_e;

  typedef enum logic {ALU_ADD, ALU_SUB} alu_op_e;

  // Next PC source
  typedef enum logic [1:0] {PC_SEQ, PC_JMP, PC_REG} pc_sel_e;

  // Fetch address source
  typedef enum logic [1:0] {ADDR_PC, ADDR_JMP, ADDR_REG} pc_addr_sel_e;

  // Operand sources, A never picks SRC_IMM8
  typedef enum logic [1:0] {SRC_RF, SRC_ALU_FWD, SRC_MEM_FWD, SRC_IMM8} alu_b_sel_e;
  typedef alu_b_sel_e alu_a_sel_e;

  // Writeback data source
  typedef enum logic [2:0] {WB_IMM8, WB_HIGH, WB_ALU, WB_PC, WB_MEM, WB_RY} rf_sel_e;

endpackage

`default_nettype wire

/* hw/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_top (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset,
  // Instruction memory, data in the cycle after the address
  input  wire logic [`CPU_WIDTH-1:0] i_pc_rddata,
  output logic      [`CPU_WIDTH-1:0] o_pc_addr,
  // Data memory, strobe and address in E
  input  wire logic [`CPU_WIDTH-1:0] i_ldst_rddata,
  output logic      [`CPU_WIDTH-1:0] o_ldst_addr,
  output logic      [`CPU_WIDTH-1:0] o_ldst_wrdata,
  output logic                       o_ldst_write
);

  // Enables and selects one way, IR words and flags back
  cpu_ctrl_if ctrl_bus ();

  cpu_control u_control (
    .i_clk,
    .i_reset,
    .ctrl         (ctrl_bus.ctrl),
    .o_ldst_write
  );

  cpu_datapath u_datapath (
    .i_clk,
    .i_reset,
    .ctrl          (ctrl_bus.dp),
    .i_pc_rddata,
    .i_ldst_rddata,
    .o_pc_addr,
    .o_ldst_addr,
    .o_ldst_wrdata
  );

endmodule

`default_nettype wire

/* hw/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile #(
  parameter int WIDTH   = 16,
  parameter int NUMREGS = 8
) (
  input  wire logic                       i_clk,
  input  wire logic                       i_reset,
  input  wire logic                       i_write,
  input  wire logic [$clog2(NUMREGS)-1:0] i_addrw,
  input  wire logic [$clog2(NUMREGS)-1:0] i_addrx,
  input  wire logic [$clog2(NUMREGS)-1:0] i_addry,
  input  wire logic [WIDTH-1:0]           i_data_in,
  output logic      [WIDTH-1:0]           o_datax,
  output logic      [WIDTH-1:0]           o_datay
);

  logic [WIDTH-1:0] r_regs [NUMREGS];

  // Register array
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      r_regs <= '{default: '0};
    end else if (i_write) begin
      r_regs[i_addrw] <= i_data_in;
    end
  end

  // Flopped read ports, address in D and data in E
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      o_datax <= '0;
      o_datay <= '0;
    end else begin
      // Same-edge write passes straight through
      o_datax <= (i_write && (i_addrw == i_addrx)) ? i_data_in : r_regs[i_addrx];
      o_datay <= (i_write && (i_addrw == i_addry)) ? i_data_in : r_regs[i_addry];
    end
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hw
hw/cpu_pkg.sv
hw/cpu_ctrl_if.sv
hw/regfile.sv
hw/alu.sv
hw/cpu_control.sv
hw/cpu_datapath.sv
hw/cpu_top.sv
tests/cpu_tb_assert.sv
tests/cpu_tb.sv

/* tests/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_tb;

  localparam int DW = `CPU_WIDTH;

  logic          i_clk = 1'b0;
  logic          i_reset;
  logic [DW-1:0] i_pc_rddata, i_ldst_rddata;
  logic [DW-1:0] o_pc_addr, o_ldst_addr, o_ldst_wrdata;
  logic          o_ldst_write;

  // Memories and a reference copy of data memory
  logic [DW-1:0] imem [256];
  logic [DW-1:0] dmem [256];
  logic [DW-1:0] dref [256];
  // Reference register file and flags
  logic [DW-1:0] mreg [8];
  logic          mf_n, mf_z;
  logic [DW-1:0] exp_addr [$];
  logic [DW-1:0] exp_data [$];
  // Outputs captured at the falling edge
  logic [DW-1:0] s_pc_addr, s_ldst_addr, s_ldst_wrdata;
  logic          s_ldst_write;
  logic [31:0]   lcg_state;
  logic [DW-1:0] end_addr, mark;
  int            pc_n, val_errs, seq_errs, asrt_errs, cycles, limit;

  cpu_top u_cpu_top (
    .i_clk,
    .i_reset,
    .i_pc_rddata,
    .o_pc_addr,
    .i_ldst_rddata,
    .o_ldst_addr,
    .o_ldst_wrdata,
    .o_ldst_write
  );

  always #2 i_clk = ~i_clk;

  function automatic logic [DW-1:0] enc_rr(cpu_pkg::opcode_e op, int rx, int ry);
    return {5'd0, 3'(ry), 3'(rx), op};
  endfunction

  function automatic logic [DW-1:0] enc_ri(cpu_pkg::opcode_e op, int rx, logic [7:0] imm);
    return {imm, 3'(rx), op};
  endfunction

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic put(logic [DW-1:0] w);
    imem[pc_n] = w;
    pc_n++;
  endtask

  // Emit a register form and update the reference model
  task automatic exec_rr(cpu_pkg::opcode_e op, int rx, int ry);
    logic [DW-1:0] r;
    put(enc_rr(op, rx, ry));
    case (op)
      cpu_pkg::OP_MV: mreg[rx] = mreg[ry];
      cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_CMP: begin
        r = (op == cpu_pkg::OP_ADD) ? mreg[rx] + mreg[ry] : mreg[rx] - mreg[ry];
        mf_n = r[DW-1];
        mf_z = (r == '0);
        if (op != cpu_pkg::OP_CMP) mreg[rx] = r;
      end
      cpu_pkg::OP_ST: begin
        exp_addr.push_back(mreg[ry]);
        exp_data.push_back(mreg[rx]);
        dref[mreg[ry][7:0]] = mreg[rx];
      end
      cpu_pkg::OP_LD: mreg[rx] = dref[mreg[ry][7:0]];
      default: ;
    endcase
  endtask

  // Immediate forms with imm8 sign extended except in mvhi
  task automatic exec_ri(cpu_pkg::opcode_e op, int rx, logic [7:0] imm);
    logic [DW-1:0] b, r;
    put(enc_ri(op, rx, imm));
    b = {{(DW-8){imm[7]}}, imm};
    case (op)
      cpu_pkg::OP_MVI:  mreg[rx] = b;
      cpu_pkg::OP_MVHI: mreg[rx] = {imm, mreg[rx][7:0]};
      default: begin
        r = (op == cpu_pkg::OP_ADDI) ? mreg[rx] + b : mreg[rx] - b;
        mf_n = r[DW-1];
        mf_z = (r == '0);
        if (op != cpu_pkg::OP_CMPI) mreg[rx] = r;
      end
    endcase
  endtask

  // Branch over one word holding a marker when taken or a real store otherwise
  task automatic branch_over(cpu_pkg::opcode_e op);
    logic taken;
    taken = (op == cpu_pkg::OP_J) || (op == cpu_pkg::OP_JZ && mf_z) ||
            (op == cpu_pkg::OP_JN && mf_n);
    put({11'd1, op});
    if (taken) put(mark);
    else exec_rr(cpu_pkg::OP_ST, 1, 0);
  endtask

  // Target built by mvi and mvhi right before the jump
  task automatic reg_jump(cpu_pkg::opcode_e op, int rx);
    logic [DW-1:0] t;
    t = DW'((pc_n + 5) * 2);
    exec_ri(cpu_pkg::OP_MVI, rx, t[7:0]);
    exec_ri(cpu_pkg::OP_MVHI, rx, t[15:8]);
    if (op == cpu_pkg::OP_CALLR) mreg[`CPU_LINK_REG] = DW'(pc_n * 2 + 2);
    put(enc_rr(op, rx, 0));
    put(mark);
    put(mark);
  endtask

  task automatic build_program();
    int            rx, ry;
    logic [7:0]    imm;
    pc_n = 0;
    // Dependent arithmetic chain
    exec_ri(cpu_pkg::OP_MVI, 0, 8'h10);
    exec_ri(cpu_pkg::OP_MVI, 1, 8'h12);
    exec_ri(cpu_pkg::OP_ADDI, 1, 8'h34);
    exec_ri(cpu_pkg::OP_MVI, 2, 8'hFD);
    exec_rr(cpu_pkg::OP_ADD, 1, 2);
    exec_rr(cpu_pkg::OP_SUB, 2, 1);
    exec_rr(cpu_pkg::OP_MV, 3, 2);
    exec_rr(cpu_pkg::OP_ST, 3, 0);
    exec_rr(cpu_pkg::OP_ST, 1, 0);
    exec_ri(cpu_pkg::OP_MVI, 4, 8'h09);
    exec_ri(cpu_pkg::OP_MVI, 5, 8'h01);
    exec_rr(cpu_pkg::OP_ADD, 4, 5);
    exec_rr(cpu_pkg::OP_ST, 4, 0);
    // Load then immediate use
    exec_ri(cpu_pkg::OP_MVI, 6, 8'h20);
    exec_rr(cpu_pkg::OP_ST, 2, 6);
    exec_rr(cpu_pkg::OP_LD, 5, 6);
    exec_rr(cpu_pkg::OP_ADD, 5, 4);
    exec_rr(cpu_pkg::OP_ST, 5, 0);
    // High byte merge
    exec_ri(cpu_pkg::OP_MVI, 3, 8'hA5);
    exec_ri(cpu_pkg::OP_MVHI, 3, 8'h7E);
    exec_rr(cpu_pkg::OP_ST, 3, 0);
    // Jumps on zero, negative and positive differences
    branch_over(cpu_pkg::OP_J);
    exec_ri(cpu_pkg::OP_MVI, 1, 8'd5);
    exec_ri(cpu_pkg::OP_CMPI, 1, 8'd5);
    branch_over(cpu_pkg::OP_JZ);
    branch_over(cpu_pkg::OP_JN);
    exec_ri(cpu_pkg::OP_CMPI, 1, 8'd7);
    branch_over(cpu_pkg::OP_JN);
    branch_over(cpu_pkg::OP_JZ);
    exec_ri(cpu_pkg::OP_MVI, 2, 8'd3);
    exec_rr(cpu_pkg::OP_CMP, 1, 2);
    branch_over(cpu_pkg::OP_JZ);
    branch_over(cpu_pkg::OP_JN);
    exec_rr(cpu_pkg::OP_CMP, 2, 1);
    branch_over(cpu_pkg::OP_JN);
    // Register jumps
    reg_jump(cpu_pkg::OP_CALLR, 2);
    exec_rr(cpu_pkg::OP_ST, 7, 0);
    reg_jump(cpu_pkg::OP_JR, 3);
    exec_rr(cpu_pkg::OP_ST, 3, 0);
    // Random mix where r6 walks the store address
    exec_ri(cpu_pkg::OP_MVI, 6, 8'h40);
    for (int i = 0; i < 40; i++) begin
      lcg_state = lcg_next(lcg_state);
      rx  = int'(lcg_state[20:16]) % 6;
      ry  = int'(lcg_state[25:21]) % 6;
      imm = lcg_state[15:8];
      case (lcg_state[31:30])
        2'd0: exec_ri(cpu_pkg::OP_MVI, rx, imm);
        2'd1: exec_ri(cpu_pkg::OP_ADDI, rx, imm);
        2'd2: exec_rr(cpu_pkg::OP_ADD, rx, ry);
        default: exec_rr(cpu_pkg::OP_SUB, rx, ry);
      endcase
      if (i % 5 == 4) begin
        exec_rr(cpu_pkg::OP_ST, rx, 6);
        exec_ri(cpu_pkg::OP_ADDI, 6, 8'd1);
      end
    end
    // Two-word idle loop at the end
    put(`CPU_NOP);
    end_addr = DW'(pc_n * 2);
    put({11'h7FE, cpu_pkg::OP_J});
  endtask

  task automatic check_store(logic [DW-1:0] a, logic [DW-1:0] d);
    logic [DW-1:0] ea, ed;
    if (exp_addr.size() == 0) begin
      $display("Unexpected extra store at time %0t: address %h data %h", $time, a, d);
      seq_errs++;
    end else begin
      ea = exp_addr.pop_front();
      ed = exp_data.pop_front();
      assert (a == ea) else begin
        $display("[FAIL] %0t store address %h, expected %h", $time, a, ea);
        val_errs++;
      end
      assert (d == ed) else begin
        $display("[FAIL] %0t store data %h, expected %h", $time, d, ed);
        val_errs++;
      end
    end
  endtask

  always @(negedge i_clk) begin
    s_pc_addr     = o_pc_addr;
    s_ldst_addr   = o_ldst_addr;
    s_ldst_wrdata = o_ldst_wrdata;
    s_ldst_write  = o_ldst_write;
  end

  // Synchronous-read memories with data valid the cycle after the address
  always @(posedge i_clk) begin
    if (s_ldst_write && !i_reset) begin
      check_store(s_ldst_addr, s_ldst_wrdata);
      dmem[s_ldst_addr[7:0]] = s_ldst_wrdata;
    end
    #1;
    i_pc_rddata   = imem[s_pc_addr[8:1]];
    i_ldst_rddata = dmem[s_ldst_addr[7:0]];
  end

  initial begin
    i_reset       = 1'b1;
    i_pc_rddata   = `CPU_NOP;
    i_ldst_rddata = '0;
    s_pc_addr     = '0;
    s_ldst_addr   = '0;
    s_ldst_wrdata = '0;
    s_ldst_write  = 1'b0;
    val_errs      = 0;
    seq_errs      = 0;
    asrt_errs     = 0;
    cycles        = 0;
    lcg_state     = 32'd82352;
    mf_n          = 1'b0;
    mf_z          = 1'b0;
    mark          = enc_rr(cpu_pkg::OP_ST, 0, 0);
    for (int i = 0; i < 256; i++) begin
      imem[i] = `CPU_NOP;
      dmem[i] = {8'(i), ~8'(i)} ^ 16'h5A3C;
      dref[i] = dmem[i];
    end
    for (int i = 0; i < 8; i++) mreg[i] = '0;
    build_program();
    limit = 4 * pc_n + 50;
    repeat (5) @(posedge i_clk);
    #1 i_reset = 1'b0;
    while (s_pc_addr != end_addr && cycles < limit) begin
      @(posedge i_clk);
      cycles++;
    end
    if (cycles >= limit) begin
      $display("Timeout: program end not reached after %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end else begin
      // Drain the last stores out of the pipe
      repeat (4) @(posedge i_clk);
      if (exp_addr.size() != 0) begin
        $display("Missing %0d expected stores", exp_addr.size());
        seq_errs += exp_addr.size();
      end
      asrt_errs = u_cpu_top.u_tb_assert.fail_cnt;
      $display("Errors: %0d value mismatches, %0d missing or extra stores, %0d assertion failures",
               val_errs, seq_errs, asrt_errs);
      if (val_errs + seq_errs + asrt_errs == 0) begin
        $display("ALL TESTS PASSED");
      end else begin
        $display("SOME TESTS FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* tests/cpu_tb_assert.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_tb_assert (
  input wire logic                  i_clk,
  input wire logic                  i_reset,
  input wire logic [`CPU_WIDTH-1:0] i_pc_addr,
  input wire logic [`CPU_WIDTH-1:0] i_ldst_addr,
  input wire logic [`CPU_WIDTH-1:0] i_ldst_wrdata,
  input wire logic                  i_ldst_write
);

  int fail_cnt = 0;

  // Pipe is full of nops right after reset
  assert property (@(posedge i_clk) $fell(i_reset) |-> !i_ldst_write)
    else begin
      $error("store strobe high in the first cycle after reset");
      fail_cnt++;
    end

  // Instructions are halfword aligned
  assert property (@(posedge i_clk) disable iff (i_reset) !i_pc_addr[0])
    else begin
      $error("odd fetch address");
      fail_cnt++;
    end

  assert property (@(posedge i_clk) disable iff (i_reset)
                   i_ldst_write |-> !$isunknown({i_ldst_addr, i_ldst_wrdata}))
    else begin
      $error("unknown store address or data");
      fail_cnt++;
    end

  // Fetch address may sit still for two cycles at most
  assert property (@(posedge i_clk) disable iff (i_reset)
                   $stable(i_pc_addr) |=> !$stable(i_pc_addr))
    else begin
      $error("fetch address held for more than two cycles");
      fail_cnt++;
    end

endmodule

bind cpu_top cpu_tb_assert u_tb_assert (
  .i_clk         (i_clk),
  .i_reset       (i_reset),
  .i_pc_addr     (o_pc_addr),
  .i_ldst_addr   (o_ldst_addr),
  .i_ldst_wrdata (o_ldst_wrdata),
  .i_ldst_write  (o_ldst_write)
);

`default_nettype wire
